// ==== Makefile ====
TOP = keystone_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^All tests passed$$"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== list.f ====
+incdir+include
logic/keystone_pkg.sv
logic/div_lane_if.sv
logic/frame_scanner.sv
logic/projection_mac.sv
logic/lane_dispatcher.sv
logic/divider_lane.sv
logic/result_collector.sv
logic/keystone_top.sv
test/keystone_tb.sv

// ==== logic/div_lane_if.sv ====
/*
 * Divider lane link
 * One request from the dispatcher, one result back to the collector
 */
`timescale 1ns/1ps

interface div_lane_if;
    import keystone_pkg::*;

    // Request, valid with the start pulse only
    logic      start;
    div_word_t num_x;
    div_word_t num_y;
    div_word_t den;
    coord_t    dst_x;
    coord_t    dst_y;

    // Lane status levels
    logic      idle;
    logic      done;

    // Result, held stable while done is high
    quot_t     quo_x;
    quot_t     quo_y;
    logic      den_positive;
    coord_t    tag_x;
    coord_t    tag_y;

    // Collector has consumed the result
    logic      take;

    modport dispatcher (output start, num_x, num_y, den, dst_x, dst_y, input idle);
    modport lane (input start, num_x, num_y, den, dst_x, dst_y, take,
                  output idle, done, quo_x, quo_y, den_positive, tag_x, tag_y);
    modport collector (input done, quo_x, quo_y, den_positive, tag_x, tag_y, output take);

endinterface

// ==== logic/divider_lane.sv ====
/*
 * Divider lane
 * Sequential restoring divide of two Q16.16 numerators by one denominator
 */
`timescale 1ns/1ps

module divider_lane (
    input  logic     clock,
    input  logic     reset,
    div_lane_if.lane lane
);
    import keystone_pkg::*;

    typedef enum logic [1:0] {st_idle, st_run, st_sign, st_done} state_t;

    state_t                       st;
    logic [$clog2(QUOT_BITS)-1:0] cnt;

    // Magnitudes and partial remainders
    logic [31:0]          dmag;
    logic [31:0]          rem_x;
    logic [31:0]          rem_y;
    // Dividend shifts out the top while quotient bits shift in below
    logic [QUOT_BITS-1:0] dvd_x;
    logic [QUOT_BITS-1:0] dvd_y;
    logic [31+QUOT_BITS:0] step_x;
    logic [31+QUOT_BITS:0] step_y;
    logic                 neg_x;
    logic                 neg_y;
    logic                 den_neg;
    logic                 den_zero;

    function automatic logic [31:0] magnitude(input div_word_t v);
        return v[31] ? -v : v;
    endfunction

    // One restoring step, returns new remainder over the shifted dividend
    function automatic logic [31+QUOT_BITS:0] div_step(
        input logic [31:0]          rem,
        input logic [QUOT_BITS-1:0] dvd,
        input logic [31:0]          d
    );
        logic [32:0] trial;
        logic [32:0] diff;
        trial = {rem, dvd[QUOT_BITS-1]};
        diff  = trial - {1'b0, d};
        if (trial >= {1'b0, d}) begin
            return {diff[31:0], dvd[QUOT_BITS-2:0], 1'b1};
        end
        return {trial[31:0], dvd[QUOT_BITS-2:0], 1'b0};
    endfunction

    assign step_x = div_step(rem_x, dvd_x, dmag);
    assign step_y = div_step(rem_y, dvd_y, dmag);

    assign lane.idle  = (st == st_idle);
    assign lane.done  = (st == st_done);
    assign lane.quo_x = dvd_x;
    assign lane.quo_y = dvd_y;

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            st  <= st_idle;
            cnt <= '0;
        end else begin
            case (st)
                st_idle: if (lane.start) begin
                    st  <= st_run;
                    cnt <= '0;
                end
                st_run: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == QUOT_BITS - 1) begin
                        st <= st_sign;
                    end
                end
                st_sign: st <= st_done;
                st_done: if (lane.take) st <= st_idle;
                default: st <= st_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (st == st_idle && lane.start) begin
            // Numerators enter shifted left by the fraction width
            dmag       <= magnitude(lane.den);
            rem_x      <= '0;
            rem_y      <= '0;
            dvd_x      <= {magnitude(lane.num_x), {FRAC_BITS{1'b0}}};
            dvd_y      <= {magnitude(lane.num_y), {FRAC_BITS{1'b0}}};
            neg_x      <= lane.num_x[31] ^ lane.den[31];
            neg_y      <= lane.num_y[31] ^ lane.den[31];
            den_neg    <= lane.den[31];
            den_zero   <= (lane.den == '0);
            lane.tag_x <= lane.dst_x;
            lane.tag_y <= lane.dst_y;
        end else if (st == st_run) begin
            {rem_x, dvd_x} <= step_x;
            {rem_y, dvd_y} <= step_y;
        end else if (st == st_sign) begin
            // Zero divisor forces zero, else restore the sign
            dvd_x <= den_zero ? '0 : (neg_x ? -dvd_x : dvd_x);
            dvd_y <= den_zero ? '0 : (neg_y ? -dvd_y : dvd_y);
            lane.den_positive <= !den_neg && !den_zero;
        end
    end

endmodule

// ==== logic/frame_scanner.sv ====
/*
 * Frame scanner
 * Latches the homography at frame start and walks the destination raster
 */
`timescale 1ns/1ps

module frame_scanner (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 frame_start,
    input  keystone_pkg::coef_t  h11,
    input  keystone_pkg::coef_t  h12,
    input  keystone_pkg::coef_t  h13,
    input  keystone_pkg::coef_t  h21,
    input  keystone_pkg::coef_t  h22,
    input  keystone_pkg::coef_t  h23,
    input  keystone_pkg::coef_t  h31,
    input  keystone_pkg::coef_t  h32,
    input  logic                 advance,
    output logic                 req_valid,
    output keystone_pkg::coord_t dst_x,
    output keystone_pkg::coord_t dst_y,
    output keystone_pkg::coef_t  coef [8],
    output logic                 frame_busy
);
    import keystone_pkg::*;

    logic consume;
    logic last_x;
    logic last_pixel;

    // One request per pixel for the whole frame
    assign req_valid  = frame_busy;
    assign consume    = req_valid && advance;
    assign last_x     = (dst_x == coord_t'(FRAME_WIDTH - 1));
    assign last_pixel = last_x && (dst_y == coord_t'(FRAME_HEIGHT - 1));

    // Coefficient latch, a start during a frame is ignored
    always_ff @(posedge clock) begin
        if (frame_start && !frame_busy) begin
            coef <= '{h11, h12, h13, h21, h22, h23, h31, h32};
        end
    end

    // Raster walk, x across the line then y down the frame
    // Wraps back to the origin after the last pixel
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frame_busy <= 1'b0;
            dst_x      <= '0;
            dst_y      <= '0;
        end else if (!frame_busy) begin
            frame_busy <= frame_start;
        end else if (consume) begin
            if (last_pixel) begin
                frame_busy <= 1'b0;
            end
            if (last_x) begin
                dst_x <= '0;
                dst_y <= last_pixel ? '0 : dst_y + 1'b1;
            end else begin
                dst_x <= dst_x + 1'b1;
            end
        end
    end

endmodule

// ==== logic/keystone_pkg.sv ====
/*
 * Keystone coordinate engine definitions
 * Frame geometry, fixed-point formats and divider bank size
 */
package keystone_pkg;

    //////////////////////////////////////////////////////////////////////
    // Geometry and sizing
    //////////////////////////////////////////////////////////////////////

    // Destination and source frame, kept small for simulation
    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 12;

    // Coefficients and quotients are Q16.16
    localparam int FRAC_BITS = 16;

    // Sums lose half the fraction before division
    localparam int PRE_SHIFT = 8;

    // 32 integer bits over 16 fraction bits
    localparam int QUOT_BITS = 48;

    // Divider bank and projection pipeline depth
    localparam int DIV_LANES  = 4;
    localparam int MAC_STAGES = 3;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [31:0] coef_t;
    typedef logic        [15:0] coord_t;
    typedef logic signed [31:0] src_coord_t;
    typedef logic signed [63:0] wide_t;
    typedef logic signed [31:0] div_word_t;
    typedef logic signed [QUOT_BITS-1:0] quot_t;

    // Round-robin pointer into the divider bank
    typedef logic [$clog2(DIV_LANES)-1:0] lane_index_t;

endpackage

// ==== logic/keystone_top.sv ====
/*
 * Keystone coordinate engine
 * Maps each destination pixel to its source coordinate by homography
 */
`timescale 1ns/1ps

module keystone_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     frame_start,
    input  keystone_pkg::coef_t      h11,
    input  keystone_pkg::coef_t      h12,
    input  keystone_pkg::coef_t      h13,
    input  keystone_pkg::coef_t      h21,
    input  keystone_pkg::coef_t      h22,
    input  keystone_pkg::coef_t      h23,
    input  keystone_pkg::coef_t      h31,
    input  keystone_pkg::coef_t      h32,
    input  logic                     out_ready,
    output logic                     frame_busy,
    output logic                     out_valid,
    output keystone_pkg::coord_t     dst_x,
    output keystone_pkg::coord_t     dst_y,
    output keystone_pkg::src_coord_t src_x,
    output keystone_pkg::src_coord_t src_y,
    output logic                     in_frame
);
    import keystone_pkg::*;

    // Scanner to projection
    logic      req_valid;
    logic      advance;
    coord_t    req_x;
    coord_t    req_y;
    coef_t     coef [8];

    // Projection to dispatcher
    logic      proj_valid;
    logic      accept;
    div_word_t num_x;
    div_word_t num_y;
    div_word_t den;
    coord_t    tag_x;
    coord_t    tag_y;

    div_lane_if lanes [DIV_LANES] ();

    frame_scanner u_scanner (
        .clock, .reset, .frame_start,
        .h11, .h12, .h13, .h21, .h22, .h23, .h31, .h32,
        .advance, .req_valid, .dst_x(req_x), .dst_y(req_y), .coef, .frame_busy
    );

    projection_mac u_mac (
        .clock, .reset, .req_valid, .dst_x(req_x), .dst_y(req_y), .coef,
        .accept, .advance, .proj_valid, .num_x, .num_y, .den, .tag_x, .tag_y
    );

    lane_dispatcher u_dispatch (
        .clock, .reset, .proj_valid, .num_x, .num_y, .den, .tag_x, .tag_y,
        .accept, .lanes(lanes)
    );

    // Divider bank, several pixels in flight
    for (genvar g = 0; g < DIV_LANES; g++) begin : g_div
        divider_lane u_lane (.clock, .reset, .lane(lanes[g]));
    end

    result_collector u_collect (
        .clock, .reset, .lanes(lanes), .out_ready, .out_valid,
        .dst_x, .dst_y, .src_x, .src_y, .in_frame
    );

endmodule

// ==== logic/lane_dispatcher.sv ====
/*
 * Lane dispatcher
 * Issues projection results to the divider bank in round-robin order
 */
`timescale 1ns/1ps

module lane_dispatcher (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    proj_valid,
    input  keystone_pkg::div_word_t num_x,
    input  keystone_pkg::div_word_t num_y,
    input  keystone_pkg::div_word_t den,
    input  keystone_pkg::coord_t    tag_x,
    input  keystone_pkg::coord_t    tag_y,
    output logic                    accept,
    div_lane_if.dispatcher          lanes [keystone_pkg::DIV_LANES]
);
    import keystone_pkg::*;

    lane_index_t          ptr;
    logic [DIV_LANES-1:0] idle_vec;
    logic                 issue;

    // Only the lane under the pointer may take work
    assign accept = idle_vec[ptr];
    assign issue  = proj_valid && accept;

    // Operands broadcast, start goes to one lane
    for (genvar g = 0; g < DIV_LANES; g++) begin : g_lane
        assign idle_vec[g]    = lanes[g].idle;
        assign lanes[g].start = issue && (ptr == lane_index_t'(g));
        assign lanes[g].num_x = num_x;
        assign lanes[g].num_y = num_y;
        assign lanes[g].den   = den;
        assign lanes[g].dst_x = tag_x;
        assign lanes[g].dst_y = tag_y;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ptr <= '0;
        end else if (issue) begin
            ptr <= (ptr == lane_index_t'(DIV_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

// ==== logic/projection_mac.sv ====
/*
 * Projection multiply-accumulate
 * Three-stage pipe forming both numerators and the homogeneous term
 */
`timescale 1ns/1ps

module projection_mac (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    req_valid,
    input  keystone_pkg::coord_t    dst_x,
    input  keystone_pkg::coord_t    dst_y,
    input  keystone_pkg::coef_t     coef [8],
    input  logic                    accept,
    output logic                    advance,
    output logic                    proj_valid,
    output keystone_pkg::div_word_t num_x,
    output keystone_pkg::div_word_t num_y,
    output keystone_pkg::div_word_t den,
    output keystone_pkg::coord_t    tag_x,
    output keystone_pkg::coord_t    tag_y
);
    import keystone_pkg::*;

    // Valid bit per stage
    logic [MAC_STAGES-1:0] vld;

    // Stage 1 products, offsets ride along with their pixel
    wide_t  p_hx1;
    wide_t  p_hy1;
    wide_t  p_hx2;
    wide_t  p_hy2;
    wide_t  p_hx3;
    wide_t  p_hy3;
    coef_t  off_x;
    coef_t  off_y;
    coord_t tag1_x;
    coord_t tag1_y;

    // Stage 2 sums
    wide_t  sum_x;
    wide_t  sum_y;
    wide_t  sum_w;
    coord_t tag2_x;
    coord_t tag2_y;

    // Whole pipe stalls when the last stage is refused
    assign proj_valid = vld[MAC_STAGES-1];
    assign advance    = !(proj_valid && !accept);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vld <= '0;
        end else if (advance) begin
            vld <= {vld[MAC_STAGES-2:0], req_valid};
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            // Stage 1
            p_hx1  <= wide_t'(coef[0]) * wide_t'(dst_x);
            p_hy1  <= wide_t'(coef[1]) * wide_t'(dst_y);
            p_hx2  <= wide_t'(coef[3]) * wide_t'(dst_x);
            p_hy2  <= wide_t'(coef[4]) * wide_t'(dst_y);
            p_hx3  <= wide_t'(coef[6]) * wide_t'(dst_x);
            p_hy3  <= wide_t'(coef[7]) * wide_t'(dst_y);
            off_x  <= coef[2];
            off_y  <= coef[5];
            tag1_x <= dst_x;
            tag1_y <= dst_y;
            // Stage 2, w gets one in Q16.16
            sum_x  <= p_hx1 + p_hy1 + wide_t'(off_x);
            sum_y  <= p_hx2 + p_hy2 + wide_t'(off_y);
            sum_w  <= p_hx3 + p_hy3 + (wide_t'(1) <<< FRAC_BITS);
            tag2_x <= tag1_x;
            tag2_y <= tag1_y;
            // Stage 3, drop PRE_SHIFT bits and keep a 32-bit word
            num_x  <= sum_x[PRE_SHIFT +: 32];
            num_y  <= sum_y[PRE_SHIFT +: 32];
            den    <= sum_w[PRE_SHIFT +: 32];
            tag_x  <= tag2_x;
            tag_y  <= tag2_y;
        end
    end

endmodule

// ==== logic/result_collector.sv ====
/*
 * Result collector
 * Drains the lanes in issue order, rounds and bounds-checks each pixel
 */
`timescale 1ns/1ps

module result_collector (
    input  logic                     clock,
    input  logic                     reset,
    div_lane_if.collector            lanes [keystone_pkg::DIV_LANES],
    input  logic                     out_ready,
    output logic                     out_valid,
    output keystone_pkg::coord_t     dst_x,
    output keystone_pkg::coord_t     dst_y,
    output keystone_pkg::src_coord_t src_x,
    output keystone_pkg::src_coord_t src_y,
    output logic                     in_frame
);
    import keystone_pkg::*;

    lane_index_t          ptr;
    logic [DIV_LANES-1:0] done_vec;
    logic [DIV_LANES-1:0] pos_vec;
    quot_t                quo_x_arr [DIV_LANES];
    quot_t                quo_y_arr [DIV_LANES];
    coord_t               tag_x_arr [DIV_LANES];
    coord_t               tag_y_arr [DIV_LANES];
    quot_t                round_x;
    quot_t                round_y;
    logic                 drain;

    // Gather lane results so the pointer can select them
    for (genvar g = 0; g < DIV_LANES; g++) begin : g_lane
        assign done_vec[g]   = lanes[g].done;
        assign pos_vec[g]    = lanes[g].den_positive;
        assign quo_x_arr[g]  = lanes[g].quo_x;
        assign quo_y_arr[g]  = lanes[g].quo_y;
        assign tag_x_arr[g]  = lanes[g].tag_x;
        assign tag_y_arr[g]  = lanes[g].tag_y;
        assign lanes[g].take = drain && (ptr == lane_index_t'(g));
    end

    assign out_valid = done_vec[ptr];
    assign drain     = out_valid && out_ready;
    assign dst_x     = tag_x_arr[ptr];
    assign dst_y     = tag_y_arr[ptr];

    // Half-up rounding, add one half then arithmetic shift
    assign round_x = quo_x_arr[ptr] + (quot_t'(1) <<< (FRAC_BITS - 1));
    assign round_y = quo_y_arr[ptr] + (quot_t'(1) <<< (FRAC_BITS - 1));
    assign src_x   = src_coord_t'(round_x >>> FRAC_BITS);
    assign src_y   = src_coord_t'(round_y >>> FRAC_BITS);

    // Inside the source frame only when w was positive
    assign in_frame = pos_vec[ptr]
                      && (src_x >= 0) && (src_x <= FRAME_WIDTH - 1)
                      && (src_y >= 0) && (src_y <= FRAME_HEIGHT - 1);

    // Same order as the dispatcher
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ptr <= '0;
        end else if (drain) begin
            ptr <= (ptr == lane_index_t'(DIV_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

// ==== include/keystone_tb_model.svh ====
/*
 * Keystone reference model
 * Projection, truncating division, half-up rounding and the bounds rule
 */
`ifndef KEYSTONE_TB_MODEL_SVH
`define KEYSTONE_TB_MODEL_SVH

// Truncating signed quotient of num shifted left by the fraction width
function automatic keystone_pkg::quot_t model_divide(
    input keystone_pkg::div_word_t num,
    input keystone_pkg::div_word_t den
);
    keystone_pkg::wide_t q;
    if (den == 0) begin
        return '0;
    end
    q = (keystone_pkg::wide_t'(num) <<< keystone_pkg::FRAC_BITS) / keystone_pkg::wide_t'(den);
    return keystone_pkg::quot_t'(q);
endfunction

// Half-up rounding to an integer coordinate
function automatic keystone_pkg::src_coord_t model_round(input keystone_pkg::quot_t q);
    keystone_pkg::quot_t r;
    r = q + (keystone_pkg::quot_t'(1) <<< (keystone_pkg::FRAC_BITS - 1));
    return keystone_pkg::src_coord_t'(r >>> keystone_pkg::FRAC_BITS);
endfunction

// Expected source coordinate and in_frame for one destination pixel
function automatic void model_pixel(
    input  keystone_pkg::coef_t      h [8],
    input  int                       x,
    input  int                       y,
    output keystone_pkg::src_coord_t sx,
    output keystone_pkg::src_coord_t sy,
    output logic                     in_frame
);
    keystone_pkg::wide_t     sum_x;
    keystone_pkg::wide_t     sum_y;
    keystone_pkg::wide_t     sum_w;
    keystone_pkg::div_word_t dw;
    sum_x = keystone_pkg::wide_t'(h[0]) * x + keystone_pkg::wide_t'(h[1]) * y + h[2];
    sum_y = keystone_pkg::wide_t'(h[3]) * x + keystone_pkg::wide_t'(h[4]) * y + h[5];
    sum_w = keystone_pkg::wide_t'(h[6]) * x + keystone_pkg::wide_t'(h[7]) * y
            + (keystone_pkg::wide_t'(1) <<< keystone_pkg::FRAC_BITS);
    dw = sum_w[keystone_pkg::PRE_SHIFT +: 32];
    sx = model_round(model_divide(sum_x[keystone_pkg::PRE_SHIFT +: 32], dw));
    sy = model_round(model_divide(sum_y[keystone_pkg::PRE_SHIFT +: 32], dw));
    in_frame = (dw > 0) && (sx >= 0) && (sx < keystone_pkg::FRAME_WIDTH)
               && (sy >= 0) && (sy < keystone_pkg::FRAME_HEIGHT);
endfunction

`endif

// ==== test/keystone_tb.sv ====
/*
 * Keystone engine testbench
 * LFSR-driven homographies, back-pressure and a queued reference model
 */
`timescale 1ns/1ps

module keystone_tb;
    import keystone_pkg::*;

    `include "keystone_tb_model.svh"

    localparam int          PIXELS         = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int          FRAMES         = 5;
    localparam int          TIMEOUT_CYCLES = FRAMES * PIXELS * 60;
    localparam logic [31:0] LFSR_SEED      = 32'h23fd_943c;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
    localparam coef_t       ONE            = 32'sh0001_0000;

    typedef struct packed {
        coord_t     dx;
        coord_t     dy;
        src_coord_t sx;
        src_coord_t sy;
        logic       inf;
    } pixel_t;

    // DUT ports
    logic       clock;
    logic       reset;
    logic       frame_start;
    coef_t      h_in [8];
    logic       out_ready;
    logic       frame_busy;
    logic       out_valid;
    coord_t     out_dst_x;
    coord_t     out_dst_y;
    src_coord_t out_src_x;
    src_coord_t out_src_y;
    logic       out_in_frame;

    // Scoreboard state
    pixel_t      expected_q [$];
    pixel_t      out_px;
    pixel_t      head;
    pixel_t      held_px;
    logic        held_valid;
    logic        identity_frame;
    int          cycle_count;
    logic [31:0] lfsr_state;
    coef_t       frame_h [8];
    coef_t       noise_h [8];

    keystone_top dut_i (
        .clock, .reset, .frame_start,
        .h11(h_in[0]), .h12(h_in[1]), .h13(h_in[2]), .h21(h_in[3]),
        .h22(h_in[4]), .h23(h_in[5]), .h31(h_in[6]), .h32(h_in[7]),
        .out_ready, .frame_busy, .out_valid,
        .dst_x(out_dst_x), .dst_y(out_dst_y), .src_x(out_src_x), .src_y(out_src_y),
        .in_frame(out_in_frame)
    );

    assign out_px = {out_dst_x, out_dst_y, out_src_x, out_src_y, out_in_frame};

    always #4 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Error reporting and random numbers
    //////////////////////////////////////////////////////////////////////

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input longint got, input longint exp);
        assert (got == exp) else
            end_with_failure($sformatf("Fail at %0t: %s is %0d, expected %0d",
                                       $time, name, got, exp));
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
        end
        return v;
    endfunction

    // Sign-extended n-bit random value
    function automatic int signed_bits(input int n);
        int v;
        v = int'(random_bits(n) << (32 - n));
        return v >>> (32 - n);
    endfunction

    // Near-identity homography with small skew, offset and perspective
    task automatic make_random_matrix(output coef_t h [8]);
        h[0] = ONE + coef_t'(signed_bits(13));
        h[1] = coef_t'(signed_bits(12));
        h[2] = coef_t'(signed_bits(19));
        h[3] = coef_t'(signed_bits(12));
        h[4] = ONE + coef_t'(signed_bits(13));
        h[5] = coef_t'(signed_bits(19));
        h[6] = coef_t'(signed_bits(9));
        h[7] = coef_t'(signed_bits(9));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            // Stalled output must not move
            if (held_valid) begin
                assert (out_valid && out_px == held_px) else
                    end_with_failure($sformatf("Fail at %0t: output changed while stalled",
                                               $time));
            end
            if (out_valid && out_ready) begin
                assert (expected_q.size() > 0) else
                    end_with_failure("An output arrived with no pixel left in the frame");
                head = expected_q.pop_front();
                check_field("dst_x", out_dst_x, head.dx);
                check_field("dst_y", out_dst_y, head.dy);
                check_field("src_x", out_src_x, head.sx);
                check_field("src_y", out_src_y, head.sy);
                check_field("in_frame", out_in_frame, head.inf);
                if (identity_frame) begin
                    check_field("identity src_x", out_src_x, head.dx);
                    check_field("identity src_y", out_src_y, head.dy);
                    check_field("identity in_frame", out_in_frame, 1);
                end
            end
            held_valid = out_valid && !out_ready;
            held_px    = out_px;
        end
    end

    // Run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            end_with_failure($sformatf("Timeout after %0d cycles, the frames never drained",
                                       cycle_count));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame sequencing
    //////////////////////////////////////////////////////////////////////

    // Expected results in raster order
    task automatic queue_frame(input coef_t h [8]);
        src_coord_t sx;
        src_coord_t sy;
        logic       inf;
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                model_pixel(h, x, y, sx, sy, inf);
                expected_q.push_back({coord_t'(x), coord_t'(y), sx, sy, inf});
            end
        end
    endtask

    // Noisy scrambles coefficients and frame_start while busy
    task automatic run_frame(input coef_t h [8], input logic noisy, input logic stall);
        h_in        = h;
        frame_start = 1'b1;
        queue_frame(h);
        @(posedge clock);
        #1;
        frame_start = 1'b0;
        assert (frame_busy) else
            end_with_failure("frame_busy did not rise after frame_start");
        while (frame_busy || expected_q.size() > 0) begin
            if (noisy && frame_busy) begin
                make_random_matrix(noise_h);
                h_in        = noise_h;
                frame_start = random_bits(1);
            end else begin
                frame_start = 1'b0;
            end
            out_ready = stall ? (random_bits(2) != 0) : 1'b1;
            @(posedge clock);
            #1;
        end
        frame_start = 1'b0;
        out_ready   = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        assert (!out_valid && !frame_busy) else
            end_with_failure("Outputs continued after the frame had drained");
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        frame_start    = 1'b0;
        out_ready      = 1'b1;
        h_in           = '{default: '0};
        held_valid     = 1'b0;
        identity_frame = 1'b0;
        cycle_count    = 0;
        lfsr_state     = LFSR_SEED;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        // Quiet until the first frame_start
        repeat (4) begin
            @(posedge clock);
            #1;
            assert (!out_valid && !frame_busy) else
                end_with_failure("out_valid or frame_busy was high before any frame");
        end

        // Identity
        identity_frame = 1'b1;
        frame_h        = '{ONE, 0, 0, 0, ONE, 0, 0, 0};
        run_frame(frame_h, 1'b0, 1'b0);
        identity_frame = 1'b0;

        // Random homographies, then stalls, then input noise
        for (int f = 0; f < 3; f++) begin
            make_random_matrix(frame_h);
            run_frame(frame_h, f == 2, f != 0);
        end

        // Strong negative h31, w crosses zero at x of 8
        frame_h = '{ONE, 0, 32'sh0000_8000, 0, ONE, 0, -32'sd8192, 0};
        run_frame(frame_h, 1'b1, 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule
